// File: Bender.yml
package:
  name: convolver

export_include_dirs:
  - .

sources:
  - conv_pkg.sv
  - lane_ram.sv
  - ir_coef_store.sv
  - conv_sequencer.sv
  - conv_lane.sv
  - lane_reduce.sv
  - convolver_top.sv
  - target: simulation
    files:
      - tb_convolver.sv

// File: conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// impulse length and lane split
`define CONV_TAPS     64
`define CONV_LANES    4
`define CONV_DEPTH    (`CONV_TAPS / `CONV_LANES)

// datapath widths
`define CONV_SAMPLE_W 16
`define CONV_COEF_W   16
`define CONV_ACC_W    48

// index widths derived from the counts above
`define CONV_LANE_W   ($clog2(`CONV_LANES))
`define CONV_ADDR_W   ($clog2(`CONV_DEPTH))
`define CONV_TAP_W    ($clog2(`CONV_TAPS))

`endif

// File: conv_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_lane #(
    parameter int LANE = 0
) (
    input  wire                        audio_clk,
    input  wire                        rst_in,
    input  wire conv_pkg::hist_wr_t    hist_wr,
    input  wire conv_pkg::step_t       step,
    input  wire conv_pkg::coef_t       coef,
    output conv_pkg::acc_t             sum,
    output logic                       done
);

    localparam conv_pkg::phase_t LANE_ID = conv_pkg::phase_t'(LANE);

    logic              we;
    conv_pkg::addr_t   rd_addr;
    conv_pkg::addr_t   ram_addr;
    conv_pkg::sample_t wdata;
    conv_pkg::sample_t rd_sample;
    conv_pkg::prod_t   prod;
    conv_pkg::acc_t    acc;
    logic              valid_q;
    logic              first_q;
    logic              last_q;
    logic              added_last;

    assign we = hist_wr.en && (hist_wr.clear_all || hist_wr.phase == LANE_ID);
    assign wdata = hist_wr.clear_all ? '0 : hist_wr.data;

    // lanes above the current phase still hold the previous block
    assign rd_addr = (LANE_ID <= step.phase) ? step.base : step.base - 1'b1;
    assign ram_addr = we ? hist_wr.addr : rd_addr;

    lane_ram #(
        .word_t (conv_pkg::sample_t),
        .DEPTH  (`CONV_DEPTH)
    ) u_hist_ram (
        .audio_clk (audio_clk),
        .we        (we),
        .addr      (ram_addr),
        .wdata     (wdata),
        .rdata     (rd_sample)
    );

    // flags line up with the ram output
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q <= 1'b0;
            added_last <= 1'b0;
            done <= 1'b0;
        end else begin
            valid_q <= step.valid;
            first_q <= step.valid && step.first;
            last_q <= step.valid && step.last;
            added_last <= valid_q && last_q;
            done <= added_last;
        end
    end

    assign prod = coef * rd_sample;

    always_ff @(posedge audio_clk) begin
        if (valid_q) begin
            acc <= first_q ? conv_pkg::acc_t'(prod) : acc + prod;
        end
    end

    assign sum = acc;

endmodule

`default_nettype wire

// File: conv_pkg.sv
`default_nettype none

package conv_pkg;

`include "conv_defs.svh"

    typedef logic signed [`CONV_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`CONV_COEF_W-1:0] coef_t;
    typedef logic signed [`CONV_SAMPLE_W+`CONV_COEF_W-1:0] prod_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    typedef logic [`CONV_LANE_W-1:0] phase_t;
    typedef logic [`CONV_ADDR_W-1:0] addr_t;
    typedef logic [`CONV_TAP_W-1:0] tap_t;

    // one entry per lane, lane 0 in the low bits
    typedef coef_t [`CONV_LANES-1:0] lane_coefs_t;
    typedef acc_t [`CONV_LANES-1:0] lane_sums_t;

    typedef struct packed {
        logic   valid;
        logic   first;
        logic   last;
        addr_t  base;
        phase_t phase;
    } step_t;

    typedef struct packed {
        logic    en;
        logic    clear_all;
        addr_t   addr;
        phase_t  phase;
        sample_t data;
    } hist_wr_t;

endpackage

`default_nettype wire

// File: conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_sequencer (
    input  wire                        audio_clk,
    input  wire                        rst_in,
    input  wire                        ir_wr,
    input  wire conv_pkg::tap_t        ir_addr,
    input  wire conv_pkg::coef_t       ir_data,
    input  wire                        ir_load_done,
    input  wire                        sample_strobe,
    input  wire conv_pkg::sample_t     sample_in,
    input  wire                        sweep_done,
    output conv_pkg::hist_wr_t         hist_wr,
    output conv_pkg::step_t            step,
    output conv_pkg::lane_coefs_t      coefs,
    output logic                       busy
);

    localparam conv_pkg::addr_t LAST_ADDR = conv_pkg::addr_t'(`CONV_DEPTH - 1);

    typedef enum logic [2:0] {
        CLEARING,
        WAIT_IMPULSE,
        IDLE,
        WRITE,
        SWEEP,
        DRAIN
    } state_t;

    state_t            state;
    conv_pkg::addr_t   clr_cnt;
    conv_pkg::addr_t   step_cnt;
    conv_pkg::addr_t   blk;
    conv_pkg::phase_t  ph;
    conv_pkg::sample_t sample_q;
    logic              ready;
    logic              accept;
    logic              coef_wr;

    // the result pulse frees the engine in the same cycle
    assign ready = (state == IDLE) || (state == DRAIN && sweep_done);
    assign accept = ready && ir_load_done && sample_strobe;
    assign busy = !(ready || state == WAIT_IMPULSE);

    // impulse is frozen while the sweep reads it
    assign coef_wr = ir_wr && (state != SWEEP);

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= CLEARING;
            clr_cnt <= '0;
            step_cnt <= '0;
            blk <= '0;
            ph <= '0;
        end else begin
            case (state)
                CLEARING: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (clr_cnt == LAST_ADDR) begin
                        state <= WAIT_IMPULSE;
                    end
                end
                WAIT_IMPULSE: begin
                    if (ir_load_done) begin
                        state <= IDLE;
                    end
                end
                WRITE: begin
                    step_cnt <= '0;
                    state <= SWEEP;
                end
                SWEEP: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_ADDR) begin
                        state <= DRAIN;
                        // block index and phase form one counter
                        {blk, ph} <= {blk, ph} + 1'b1;
                    end
                end
                IDLE, DRAIN: begin
                    if (accept) begin
                        state <= WRITE;
                    end else if (ready) begin
                        state <= ir_load_done ? IDLE : WAIT_IMPULSE;
                    end
                end
                default: begin
                    state <= CLEARING;
                end
            endcase
        end
    end

    always_ff @(posedge audio_clk) begin
        if (accept) begin
            sample_q <= sample_in;
        end
    end

    always_comb begin
        hist_wr = '0;
        if (state == CLEARING) begin
            hist_wr.en = 1'b1;
            hist_wr.clear_all = 1'b1;
            hist_wr.addr = clr_cnt;
        end else if (state == WRITE) begin
            hist_wr.en = 1'b1;
            hist_wr.addr = blk;
            hist_wr.phase = ph;
            hist_wr.data = sample_q;
        end
    end

    always_comb begin
        step.valid = (state == SWEEP);
        step.first = step.valid && (step_cnt == '0);
        step.last = step.valid && (step_cnt == LAST_ADDR);
        step.base = blk - step_cnt;
        step.phase = ph;
    end

    ir_coef_store u_ir_coef_store (
        .audio_clk (audio_clk),
        .rst_in    (rst_in),
        .ir_wr     (coef_wr),
        .ir_addr   (ir_addr),
        .ir_data   (ir_data),
        .rd_en     (step.valid),
        .rd_addr   (step_cnt),
        .phase     (ph),
        .coefs     (coefs)
    );

endmodule

`default_nettype wire

// File: convolver_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module convolver_top (
    input  wire                        audio_clk,
    input  wire                        rst_in,
    input  wire                        ir_wr,
    input  wire conv_pkg::tap_t        ir_addr,
    input  wire conv_pkg::coef_t       ir_data,
    input  wire                        ir_load_done,
    input  wire                        sample_strobe,
    input  wire conv_pkg::sample_t     sample_in,
    output conv_pkg::acc_t             result,
    output logic                       result_valid,
    output logic                       busy
);

    wire conv_pkg::hist_wr_t    hist_wr;
    wire conv_pkg::step_t       step;
    wire conv_pkg::lane_coefs_t coefs;
    wire conv_pkg::lane_sums_t  sums;
    wire [`CONV_LANES-1:0]      lane_done;

    conv_sequencer u_conv_sequencer (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .ir_wr         (ir_wr),
        .ir_addr       (ir_addr),
        .ir_data       (ir_data),
        .ir_load_done  (ir_load_done),
        .sample_strobe (sample_strobe),
        .sample_in     (sample_in),
        .sweep_done    (result_valid),
        .hist_wr       (hist_wr),
        .step          (step),
        .coefs         (coefs),
        .busy          (busy)
    );

    for (genvar q = 0; q < `CONV_LANES; q++) begin : g_lane
        conv_lane #(
            .LANE (q)
        ) u_conv_lane (
            .audio_clk (audio_clk),
            .rst_in    (rst_in),
            .hist_wr   (hist_wr),
            .step      (step),
            .coef      (coefs[q]),
            .sum       (sums[q]),
            .done      (lane_done[q])
        );
    end

    // all lanes finish together, lane 0 stands for the rest
    lane_reduce u_lane_reduce (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .sums         (sums),
        .sums_valid   (lane_done[0]),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
conv_pkg.sv
lane_ram.sv
ir_coef_store.sv
conv_sequencer.sv
conv_lane.sv
lane_reduce.sv
convolver_top.sv
tb_convolver.sv

// File: ir_coef_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module ir_coef_store (
    input  wire                        audio_clk,
    input  wire                        rst_in,
    input  wire                        ir_wr,
    input  wire conv_pkg::tap_t        ir_addr,
    input  wire conv_pkg::coef_t       ir_data,
    input  wire                        rd_en,
    input  wire conv_pkg::addr_t       rd_addr,
    input  wire conv_pkg::phase_t      phase,
    output conv_pkg::lane_coefs_t      coefs
);

    wire conv_pkg::coef_t bank_rd [`CONV_LANES];
    conv_pkg::phase_t phase_q;

    // bank b holds taps b, b+L, b+2L, ...
    for (genvar b = 0; b < `CONV_LANES; b++) begin : g_bank
        logic            bank_we;
        conv_pkg::addr_t bank_addr;

        assign bank_we = ir_wr && (ir_addr[`CONV_LANE_W-1:0] == conv_pkg::phase_t'(b));
        assign bank_addr = ir_wr ? ir_addr[`CONV_TAP_W-1:`CONV_LANE_W] : rd_addr;

        lane_ram #(
            .word_t (conv_pkg::coef_t),
            .DEPTH  (`CONV_DEPTH)
        ) u_coef_ram (
            .audio_clk (audio_clk),
            .we        (bank_we),
            .addr      (bank_addr),
            .wdata     (ir_data),
            .rdata     (bank_rd[b])
        );
    end

    // phase follows the ram read by one cycle
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            phase_q <= '0;
        end else if (rd_en) begin
            phase_q <= phase;
        end
    end

    // lane q takes bank (s - q) mod L
    always_comb begin
        conv_pkg::phase_t src;
        src = '0;
        for (int q = 0; q < `CONV_LANES; q++) begin
            src = phase_q - conv_pkg::phase_t'(q);
            coefs[q] = bank_rd[src];
        end
    end

endmodule

`default_nettype wire

// File: lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single port ram, read returns the old word on a write
module lane_ram #(
    parameter type word_t = logic [15:0],
    parameter int DEPTH = 16
) (
    input  wire                       audio_clk,
    input  wire                       we,
    input  wire [$clog2(DEPTH)-1:0]   addr,
    input  wire word_t                wdata,
    output word_t                     rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge audio_clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: lane_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module lane_reduce (
    input  wire                        audio_clk,
    input  wire                        rst_in,
    input  wire conv_pkg::lane_sums_t  sums,
    input  wire                        sums_valid,
    output conv_pkg::acc_t             result,
    output logic                       result_valid
);

    localparam conv_pkg::phase_t LAST_IDX = conv_pkg::phase_t'(`CONV_LANES - 1);

    conv_pkg::lane_sums_t sums_q;
    conv_pkg::acc_t       total;
    conv_pkg::phase_t     idx;
    logic                 active;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            active <= 1'b0;
            idx <= '0;
            result <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (sums_valid) begin
                active <= 1'b1;
                idx <= '0;
            end else if (active) begin
                idx <= idx + 1'b1;
                if (idx == LAST_IDX) begin
                    active <= 1'b0;
                    result <= total + sums_q[idx];
                    result_valid <= 1'b1;
                end
            end
        end
    end

    // one lane sum per cycle
    always_ff @(posedge audio_clk) begin
        if (sums_valid) begin
            sums_q <= sums;
            total <= '0;
        end else if (active) begin
            total <= total + sums_q[idx];
        end
    end

endmodule

`default_nettype wire

// File: tb_convolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module tb_convolver;

    localparam int LATENCY = `CONV_DEPTH + `CONV_LANES + 5;
    localparam int BUSY_TIMEOUT = 200;
    localparam int RESULT_TIMEOUT = 100;
    localparam int ROWS = 5;

    typedef enum {IR_UNIT, IR_TAP37, IR_RANDOM, IR_NEG_FULL} ir_kind_t;
    typedef enum {SRC_FIXED, SRC_RANDOM, SRC_NEG_FULL} src_t;

    typedef struct {
        string    name;
        ir_kind_t ir_kind;
        int       count;
        src_t     src;
        bit       gate;
    } row_t;

    logic                  audio_clk;
    logic                  rst_in;
    logic                  ir_wr;
    conv_pkg::tap_t        ir_addr;
    conv_pkg::coef_t       ir_data;
    logic                  ir_load_done;
    logic                  sample_strobe;
    conv_pkg::sample_t     sample_in;
    conv_pkg::acc_t        result;
    logic                  result_valid;
    logic                  busy;

    row_t                  rows [ROWS];
    conv_pkg::sample_t     fixed_list [16];
    conv_pkg::coef_t       h_ref [`CONV_TAPS];
    conv_pkg::sample_t     x_ref [256];
    logic [31:0]           rng_state = 32'd54850;
    int                    pulse_cnt = 0;
    int                    mismatch_cnt = 0;
    int                    other_cnt = 0;

    convolver_top u_convolver_top (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .ir_wr         (ir_wr),
        .ir_addr       (ir_addr),
        .ir_data       (ir_data),
        .ir_load_done  (ir_load_done),
        .sample_strobe (sample_strobe),
        .sample_in     (sample_in),
        .result        (result),
        .result_valid  (result_valid),
        .busy          (busy)
    );

    initial begin
        audio_clk = 1'b0;
        forever #10 audio_clk = ~audio_clk;
    end

    // every result pulse, wanted or not
    always @(posedge audio_clk) begin
        if (result_valid === 1'b1) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic conv_pkg::coef_t impulse_coef(input ir_kind_t kind, input int k);
        conv_pkg::coef_t c;
        case (kind)
            IR_UNIT: c = (k == 0) ? 16'sd1 : 16'sd0;
            IR_TAP37: c = (k == 37) ? -16'sd3 : 16'sd0;
            IR_RANDOM: begin
                rng_state = xorshift32(rng_state);
                c = conv_pkg::coef_t'(rng_state[15:0]);
            end
            default: c = conv_pkg::coef_t'(16'h8000);
        endcase
        return c;
    endfunction

    function automatic conv_pkg::sample_t sample_for(input src_t src, input int i);
        conv_pkg::sample_t v;
        case (src)
            SRC_RANDOM: begin
                rng_state = xorshift32(rng_state);
                v = conv_pkg::sample_t'(rng_state[15:0]);
            end
            SRC_NEG_FULL: v = conv_pkg::sample_t'(16'h8000);
            default: v = fixed_list[i % 16];
        endcase
        return v;
    endfunction

    // y[n] = sum of h[k] * x[n-k], silence before the first sample
    function automatic conv_pkg::acc_t model_output(input int n);
        longint sum;
        sum = 0;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            if (n - k >= 0) begin
                sum += longint'(h_ref[k]) * longint'(x_ref[n - k]);
            end
        end
        return conv_pkg::acc_t'(sum);
    endfunction

    task automatic check_result(input string name, input conv_pkg::acc_t expected,
                                input conv_pkg::acc_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0d actual %0d", name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s: expected %0d actual %0d", name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    task automatic next_cycle();
        @(posedge audio_clk);
        #2;
    endtask

    task automatic wait_not_busy(input string name, output bit ok);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < BUSY_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        ok = (busy === 1'b0);
        if (!ok) begin
            $display("%s: busy stayed high for %0d cycles", name, BUSY_TIMEOUT);
            other_cnt++;
        end
    endtask

    task automatic reset_dut();
        rst_in = 1'b1;
        ir_wr = 1'b0;
        ir_load_done = 1'b0;
        sample_strobe = 1'b0;
        repeat (2) next_cycle();
        rst_in = 1'b0;
    endtask

    task automatic load_impulse(input ir_kind_t kind);
        for (int k = 0; k < `CONV_TAPS; k++) begin
            h_ref[k] = impulse_coef(kind, k);
            ir_wr = 1'b1;
            ir_addr = conv_pkg::tap_t'(k);
            ir_data = h_ref[k];
            next_cycle();
        end
        ir_wr = 1'b0;
    endtask

    task automatic send_sample(input string name, input conv_pkg::sample_t value,
                               input bit inject_busy, output bit ok,
                               output conv_pkg::acc_t got, output int cycles);
        got = '0;
        cycles = 0;
        wait_not_busy(name, ok);
        if (!ok) begin
            return;
        end
        sample_strobe = 1'b1;
        sample_in = value;
        next_cycle();
        sample_strobe = 1'b0;
        cycles = 1;
        while (result_valid !== 1'b1 && cycles < RESULT_TIMEOUT) begin
            // this strobe lands mid sweep and must be dropped
            if (inject_busy && cycles == 6) begin
                if (busy !== 1'b1) begin
                    $display("%s: busy was low during the sweep", name);
                    other_cnt++;
                end
                sample_strobe = 1'b1;
                sample_in = 16'sh7abc;
            end
            next_cycle();
            sample_strobe = 1'b0;
            cycles++;
        end
        ok = (result_valid === 1'b1);
        got = result;
        if (!ok) begin
            $display("%s: no result pulse within %0d cycles", name, RESULT_TIMEOUT);
            other_cnt++;
        end
    endtask

    task automatic run_row(input row_t row);
        bit             ok;
        conv_pkg::acc_t got;
        int             cycles;
        int             start_cnt;
        reset_dut();
        wait_not_busy({row.name, " clear"}, ok);
        load_impulse(row.ir_kind);
        start_cnt = pulse_cnt;
        if (row.gate) begin
            // engine waits for the impulse, these go nowhere
            for (int i = 0; i < 3; i++) begin
                sample_strobe = 1'b1;
                sample_in = fixed_list[i];
                next_cycle();
                sample_strobe = 1'b0;
                repeat (4) next_cycle();
            end
            repeat (LATENCY + 10) next_cycle();
        end
        ir_load_done = 1'b1;
        next_cycle();
        for (int i = 0; i < row.count; i++) begin
            x_ref[i] = sample_for(row.src, i);
            send_sample(row.name, x_ref[i], row.gate, ok, got, cycles);
            if (ok) begin
                check_result($sformatf("%s sample %0d", row.name, i), model_output(i), got);
                check_count($sformatf("%s latency %0d", row.name, i), LATENCY, cycles);
            end
        end
        repeat (LATENCY + 5) next_cycle();
        check_count({row.name, " pulses"}, row.count, pulse_cnt - start_cnt);
    endtask

    initial begin
        rst_in = 1'b1;
        ir_wr = 1'b0;
        ir_addr = '0;
        ir_data = '0;
        ir_load_done = 1'b0;
        sample_strobe = 1'b0;
        sample_in = '0;

        fixed_list = '{1, -1, 100, -250, 32767, -32768, 12345, -4321,
                       7, 0, 555, -9999, 2048, -2048, 31000, -17};

        rows[0] = '{"unit_tap0", IR_UNIT, 20, SRC_FIXED, 1'b0};
        rows[1] = '{"tap37_neg3", IR_TAP37, 48, SRC_FIXED, 1'b0};
        rows[2] = '{"random_wrap", IR_RANDOM, 150, SRC_RANDOM, 1'b0};
        rows[3] = '{"full_scale_neg", IR_NEG_FULL, 70, SRC_NEG_FULL, 1'b0};
        rows[4] = '{"dropped_strobes", IR_RANDOM, 12, SRC_FIXED, 1'b1};

        for (int r = 0; r < ROWS; r++) begin
            run_row(rows[r]);
        end

        $display("%0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
